/* Makefile */
TOP = mmio_bridge_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps -f mmio_bridge.f \
		--top-module $(TOP) -o V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only -Wall --timescale 1ns/1ps +incdir+include \
		rtl/mmio_pkg.sv rtl/mmio_addr_decode.sv rtl/mmio_store_regs.sv \
		rtl/mmio_counters.sv rtl/mmio_load_mux.sv rtl/mmio_bridge.sv \
		--top-module mmio_bridge

clean:
	rm -rf obj_dir

/* include/mmio_consts.svh */
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// --------------------
// peripheral space, 0x8000_00xx
// --------------------
`define MMIO_ADDR_CYCLES      32'h8000_0010
`define MMIO_ADDR_INSTRS      32'h8000_0014
`define MMIO_ADDR_CNT_RESET   32'h8000_0018  // store clears both counters
`define MMIO_ADDR_SWITCHES    32'h8000_0028
`define MMIO_ADDR_LEDS        32'h8000_0030  // board leds in 5:0, pmod in 15:8
`define MMIO_ADDR_TONE_EN     32'h8000_0034
`define MMIO_ADDR_TONE_PERIOD 32'h8000_0038
`define MMIO_ADDR_AUDIO_FULL  32'h8000_0040
`define MMIO_ADDR_AUDIO_DIN   32'h8000_0044

// --------------------
// hdmi line drawer, 0xA001_00xx
// --------------------
`define MMIO_ADDR_HDMI_X0     32'hA001_0000
`define MMIO_ADDR_HDMI_X1     32'hA001_0004
`define MMIO_ADDR_HDMI_Y0     32'hA001_0008
`define MMIO_ADDR_HDMI_Y1     32'hA001_000C
`define MMIO_ADDR_HDMI_COLOR  32'hA001_0010
`define MMIO_ADDR_HDMI_FIRE   32'hA001_0014

// framebuffer stores are tagged in the top nibble
`define MMIO_FB_TAG           4'h9

// tone period out of reset
`define MMIO_TONE_RESET       24'h000555

// field widths
`define MMIO_SAMPLE_W         24
`define MMIO_COORD_W          10
`define MMIO_FB_ADDR_W        20

`endif

/* mmio_bridge.f */
+incdir+include
rtl/mmio_pkg.sv
rtl/mmio_addr_decode.sv
rtl/mmio_store_regs.sv
rtl/mmio_counters.sv
rtl/mmio_load_mux.sv
rtl/mmio_bridge.sv
verif/tb_clock.sv
verif/mmio_bridge_tb.sv

/* rtl/mmio_addr_decode.sv */
`timescale 1ns/1ps
`include "mmio_consts.svh"

module mmio_addr_decode import mmio_pkg::*; (
    input  logic      clk,   // only clocks the select check
    input  mmio_req_t req,
    output mmio_sel_t sel
);

    mmio_addr_u addr;

    assign addr = req.addr;

    // region nibble first, then the word offset inside it
    function automatic logic addr_is(input mmio_addr_u a, input logic [31:0] k);
        return (a.regs.region == k[31:28]) && (a.regs.offset == k[27:0]);
    endfunction

    always_comb begin
        sel = '0;

        // --------------------
        // stores
        // --------------------
        if (req.store) begin
            sel.leds        = addr_is(addr, `MMIO_ADDR_LEDS);
            sel.tone_en     = addr_is(addr, `MMIO_ADDR_TONE_EN);
            sel.tone_period = addr_is(addr, `MMIO_ADDR_TONE_PERIOD);
            sel.audio_din   = addr_is(addr, `MMIO_ADDR_AUDIO_DIN);
            sel.cnt_reset   = addr_is(addr, `MMIO_ADDR_CNT_RESET);
            sel.hdmi_x0     = addr_is(addr, `MMIO_ADDR_HDMI_X0);
            sel.hdmi_x1     = addr_is(addr, `MMIO_ADDR_HDMI_X1);
            sel.hdmi_y0     = addr_is(addr, `MMIO_ADDR_HDMI_Y0);
            sel.hdmi_y1     = addr_is(addr, `MMIO_ADDR_HDMI_Y1);
            sel.hdmi_color  = addr_is(addr, `MMIO_ADDR_HDMI_COLOR);
            sel.hdmi_fire   = addr_is(addr, `MMIO_ADDR_HDMI_FIRE);
            sel.fb          = (addr.fb.tag == `MMIO_FB_TAG);  // whole region, any offset
        end

        // --------------------
        // loads
        // --------------------
        if (req.load) begin
            sel.cycles     = addr_is(addr, `MMIO_ADDR_CYCLES);
            sel.instrs     = addr_is(addr, `MMIO_ADDR_INSTRS);
            sel.switches   = addr_is(addr, `MMIO_ADDR_SWITCHES);
            sel.audio_full = addr_is(addr, `MMIO_ADDR_AUDIO_FULL);
        end
    end

    // at most one register hit per access, so downstream
    // stages never see two writers or two read sources
    a_sel_onehot0: assert property (
        @(posedge clk) !$isunknown(req) |-> $onehot0(sel)
    ) else $error("mmio decode: select not one-hot, sel=%b", sel);

endmodule

/* rtl/mmio_bridge.sv */
`timescale 1ns/1ps

module mmio_bridge import mmio_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  mmio_req_t   req,
    input  logic        retire,
    input  logic [1:0]  switches,
    input  logic        audio_full,
    input  logic        hdmi_ready,
    output periph_out_t periph,
    output logic        rd_valid,
    output logic [31:0] rd_data
);

    mmio_sel_t   sel;
    mmio_addr_u  req_addr;   // framebuffer view feeds the pixel index
    logic [31:0] cycle_count;
    logic [31:0] instr_count;

    assign req_addr = req.addr;

    // --------------------
    // decode, zero cycles
    // --------------------
    mmio_addr_decode decode0 (
        .clk (clk),
        .req (req),
        .sel (sel)
    );

    // --------------------
    // one cycle stages
    // --------------------
    mmio_store_regs store0 (
        .clk        (clk),
        .rst        (rst),
        .sel        (sel),
        .wdata      (req.wdata),
        .pixel_addr (req_addr.fb.pixel),
        .hdmi_ready (hdmi_ready),
        .periph     (periph)
    );

    mmio_counters counters0 (
        .clk         (clk),
        .rst         (rst),
        .retire      (retire),
        .clear       (sel.cnt_reset),
        .cycle_count (cycle_count),
        .instr_count (instr_count)
    );

    mmio_load_mux load0 (
        .clk         (clk),
        .rst         (rst),
        .sel         (sel),
        .load        (req.load),
        .cycle_count (cycle_count),
        .instr_count (instr_count),
        .switches    (switches),
        .audio_full  (audio_full),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

endmodule

/* rtl/mmio_counters.sv */
`timescale 1ns/1ps

module mmio_counters (
    input  logic        clk,
    input  logic        rst,
    input  logic        retire,       // one instruction left the pipe
    input  logic        clear,        // counter-reset store
    output logic [31:0] cycle_count,
    output logic [31:0] instr_count
);

    // free running cycle count
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 32'd1;
        end
    end

    // only counts while the core is not stalling
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            instr_count <= '0;
        end else if (retire) begin
            instr_count <= instr_count + 32'd1;
        end
    end

    // both clear together, and at most one retire per cycle, so the
    // instruction count can never pass the cycle count
    a_instr_le_cycle: assert property (
        @(posedge clk) disable iff (rst)
        instr_count <= cycle_count
    ) else $error("mmio counters: instr %0d ahead of cycles %0d",
                  instr_count, cycle_count);

endmodule

/* rtl/mmio_load_mux.sv */
`timescale 1ns/1ps

module mmio_load_mux import mmio_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  mmio_sel_t   sel,
    input  logic        load,
    input  logic [31:0] cycle_count,
    input  logic [31:0] instr_count,
    input  logic [1:0]  switches,
    input  logic        audio_full,
    output logic        rd_valid,
    output logic [31:0] rd_data
);

    logic [31:0] load_word;

    // --------------------
    // source select
    // --------------------
    // unmapped loads fall through to zero
    always_comb begin
        load_word = '0;
        if (sel.cycles) begin
            load_word = cycle_count;
        end else if (sel.instrs) begin
            load_word = instr_count;
        end else if (sel.switches) begin
            load_word = {30'b0, switches};
        end else if (sel.audio_full) begin
            load_word = {31'b0, audio_full};
        end
    end

    // --------------------
    // result stage
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
        end else begin
            rd_valid <= load;       // every load answers, mapped or not
            rd_data  <= load_word;  // counters sampled at request time
        end
    end

endmodule

/* rtl/mmio_pkg.sv */
`include "mmio_consts.svh"

package mmio_pkg;

    // one access from the execute stage
    typedef struct packed {
        logic        load;
        logic        store;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mmio_req_t;

    // same address word, register view or framebuffer view
    typedef union packed {
        struct packed {
            logic [3:0]  region;
            logic [27:0] offset;
        } regs;
        struct packed {
            logic [3:0]                 tag;
            logic [7:0]                 unused;
            logic [`MMIO_FB_ADDR_W-1:0] pixel;
        } fb;
    } mmio_addr_u;

    // one-hot register select, stores first then loads
    typedef struct packed {
        logic leds;
        logic tone_en;
        logic tone_period;
        logic audio_din;
        logic fb;
        logic hdmi_x0;
        logic hdmi_x1;
        logic hdmi_y0;
        logic hdmi_y1;
        logic hdmi_color;
        logic hdmi_fire;
        logic cnt_reset;
        logic cycles;       // loads from here down
        logic instrs;
        logic switches;
        logic audio_full;
    } mmio_sel_t;

    typedef struct packed {
        logic [5:0]                 leds;
        logic [7:0]                 pmod_leds;
        logic                       tone_en;
        logic [23:0]                tone_period;
        logic [`MMIO_SAMPLE_W-1:0]  audio_din;
        logic                       audio_wr_en;
        logic                       fb_we;
        logic [`MMIO_FB_ADDR_W-1:0] fb_addr;
        logic                       fb_data;
        logic [`MMIO_COORD_W-1:0]   x0;
        logic [`MMIO_COORD_W-1:0]   x1;
        logic [`MMIO_COORD_W-1:0]   y0;
        logic [`MMIO_COORD_W-1:0]   y1;
        logic                       color;
        logic                       hdmi_valid;
    } periph_out_t;

endpackage

/* rtl/mmio_store_regs.sv */
`timescale 1ns/1ps
`include "mmio_consts.svh"

module mmio_store_regs import mmio_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  mmio_sel_t                  sel,
    input  logic [31:0]                wdata,
    input  logic [`MMIO_FB_ADDR_W-1:0] pixel_addr,  // framebuffer view of the address
    input  logic                       hdmi_ready,
    output periph_out_t                periph
);

    always_ff @(posedge clk) begin
        if (rst) begin
            periph             <= '0;
            periph.tone_period <= `MMIO_TONE_RESET;
        end else begin
            // --------------------
            // single cycle strobes
            // --------------------
            periph.audio_wr_en <= sel.audio_din;
            periph.fb_we       <= sel.fb;
            periph.hdmi_valid  <= sel.hdmi_fire && hdmi_ready;  // fire lost if not ready

            // --------------------
            // gpio and tone
            // --------------------
            if (sel.leds) begin
                periph.leds      <= wdata[5:0];
                periph.pmod_leds <= wdata[15:8];
            end
            if (sel.tone_en) begin
                periph.tone_en <= wdata[0];
            end
            if (sel.tone_period) begin
                periph.tone_period <= wdata[23:0];
            end

            // sample stays on the bus after the write pulse
            if (sel.audio_din) begin
                periph.audio_din <= wdata[`MMIO_SAMPLE_W-1:0];
            end

            // pixel write, one bit per pixel
            if (sel.fb) begin
                periph.fb_addr <= pixel_addr;
                periph.fb_data <= wdata[0];
            end

            // --------------------
            // hdmi line registers
            // --------------------
            if (sel.hdmi_x0) begin
                periph.x0 <= wdata[`MMIO_COORD_W-1:0];
            end
            if (sel.hdmi_x1) begin
                periph.x1 <= wdata[`MMIO_COORD_W-1:0];
            end
            if (sel.hdmi_y0) begin
                periph.y0 <= wdata[`MMIO_COORD_W-1:0];
            end
            if (sel.hdmi_y1) begin
                periph.y1 <= wdata[`MMIO_COORD_W-1:0];
            end
            if (sel.hdmi_color) begin
                periph.color <= wdata[0];
            end
        end
    end

    // valid is a pulse per accepted fire; it may only stay high into a second
    // cycle when another fire was accepted while it was up
    a_hdmi_valid_pulse: assert property (
        @(posedge clk) disable iff (rst)
        periph.hdmi_valid && !(sel.hdmi_fire && hdmi_ready) |=> !periph.hdmi_valid
    ) else $error("mmio store: hdmi_valid held without a new fire");

endmodule

/* verif/mmio_bridge_tb.sv */
`timescale 1ns/1ps
`include "mmio_consts.svh"

module mmio_bridge_tb import mmio_pkg::*; ();

    localparam int N_REQ         = 3000;
    localparam int RESET_TIMEOUT = 20;  // cycles
    localparam int DRAIN_TIMEOUT = 20;

    logic        clk;
    logic        rst;
    mmio_req_t   req;
    logic        retire;
    logic [1:0]  switches;
    logic        audio_full;
    logic        hdmi_ready;
    periph_out_t periph;
    logic        rd_valid;
    logic [31:0] rd_data;

    // reference model state
    periph_out_t exp_periph;
    logic        exp_valid;
    logic [31:0] exp_data;
    logic [31:0] exp_cycles;
    logic [31:0] exp_instrs;
    logic [31:0] rng_state;
    logic [31:0] named_addr [0:14];

    tb_clock clock0 (.clk(clk));

    mmio_bridge dut0 (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .retire     (retire),
        .switches   (switches),
        .audio_full (audio_full),
        .hdmi_ready (hdmi_ready),
        .periph     (periph),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data)
    );

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("FAIL %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
            stop_run();
        end
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_word(input logic [31:0] got, input logic [31:0] want);
        compare_value("rd_data", got, want);
    endtask

    task automatic check_bit(input logic got, input logic want);
        compare_value("rd_valid", 32'(got), 32'(want));
    endtask

    task automatic check_periph(input periph_out_t got, input periph_out_t want);
        compare_value("periph.leds", 32'(got.leds), 32'(want.leds));
        compare_value("periph.pmod_leds", 32'(got.pmod_leds), 32'(want.pmod_leds));
        compare_value("periph.tone_en", 32'(got.tone_en), 32'(want.tone_en));
        compare_value("periph.tone_period", 32'(got.tone_period), 32'(want.tone_period));
        compare_value("periph.audio_din", 32'(got.audio_din), 32'(want.audio_din));
        compare_value("periph.audio_wr_en", 32'(got.audio_wr_en), 32'(want.audio_wr_en));
        compare_value("periph.fb_we", 32'(got.fb_we), 32'(want.fb_we));
        compare_value("periph.fb_addr", 32'(got.fb_addr), 32'(want.fb_addr));
        compare_value("periph.fb_data", 32'(got.fb_data), 32'(want.fb_data));
        compare_value("periph.x0", 32'(got.x0), 32'(want.x0));
        compare_value("periph.x1", 32'(got.x1), 32'(want.x1));
        compare_value("periph.y0", 32'(got.y0), 32'(want.y0));
        compare_value("periph.y1", 32'(got.y1), 32'(want.y1));
        compare_value("periph.color", 32'(got.color), 32'(want.color));
        compare_value("periph.hdmi_valid", 32'(got.hdmi_valid), 32'(want.hdmi_valid));
    endtask

    // --------------------
    // reference model
    // --------------------
    // called on the edge, sees the request that was presented this cycle
    task automatic step_model();
        periph_out_t p;
        logic [31:0] a;
        p             = exp_periph;
        a             = req.addr;
        p.audio_wr_en = 1'b0;  // strobes last one cycle
        p.fb_we       = 1'b0;
        p.hdmi_valid  = 1'b0;
        exp_valid     = req.load;
        exp_data      = '0;
        if (req.load) begin
            case (a)
                `MMIO_ADDR_CYCLES:     exp_data = exp_cycles;  // value before the edge
                `MMIO_ADDR_INSTRS:     exp_data = exp_instrs;
                `MMIO_ADDR_SWITCHES:   exp_data = {30'b0, switches};
                `MMIO_ADDR_AUDIO_FULL: exp_data = {31'b0, audio_full};
                default:               exp_data = '0;
            endcase
        end
        exp_cycles = exp_cycles + 32'd1;
        exp_instrs = exp_instrs + {31'b0, retire};
        if (req.store && a[31:28] == `MMIO_FB_TAG) begin
            p.fb_we   = 1'b1;
            p.fb_addr = a[19:0];
            p.fb_data = req.wdata[0];
        end else if (req.store) begin
            case (a)
                `MMIO_ADDR_LEDS: begin
                    p.leds      = req.wdata[5:0];
                    p.pmod_leds = req.wdata[15:8];
                end
                `MMIO_ADDR_TONE_EN:     p.tone_en = req.wdata[0];
                `MMIO_ADDR_TONE_PERIOD: p.tone_period = req.wdata[23:0];
                `MMIO_ADDR_AUDIO_DIN: begin
                    p.audio_wr_en = 1'b1;
                    p.audio_din   = req.wdata[23:0];
                end
                `MMIO_ADDR_HDMI_X0:    p.x0 = req.wdata[9:0];
                `MMIO_ADDR_HDMI_X1:    p.x1 = req.wdata[9:0];
                `MMIO_ADDR_HDMI_Y0:    p.y0 = req.wdata[9:0];
                `MMIO_ADDR_HDMI_Y1:    p.y1 = req.wdata[9:0];
                `MMIO_ADDR_HDMI_COLOR: p.color = req.wdata[0];
                `MMIO_ADDR_HDMI_FIRE:  p.hdmi_valid = hdmi_ready;  // dropped when busy
                `MMIO_ADDR_CNT_RESET: begin
                    exp_cycles = '0;
                    exp_instrs = '0;
                end
                default: ;
            endcase
        end
        exp_periph = p;
    endtask

    // advance the model on the edge, drive the next request, check mid-cycle
    task automatic run_cycle(input logic idle);
        logic [31:0] r;
        logic [31:0] s;
        mmio_req_t   nreq;
        @(posedge clk);
        step_model();
        r          = lcg_next();
        s          = lcg_next();
        nreq       = '0;
        nreq.wdata = lcg_next();
        if (!idle) begin
            case (r[31:28])
                4'h0, 4'h1: ;  // idle cycle
                4'h2, 4'h3, 4'h4, 4'h5, 4'h6: begin
                    nreq.store = 1'b1;
                    nreq.addr  = named_addr[4'(r[23:8] % 16'd15)];
                end
                4'h7, 4'h8, 4'h9, 4'hA: begin
                    nreq.load = 1'b1;
                    nreq.addr = named_addr[4'(r[23:8] % 16'd15)];
                end
                4'hB, 4'hC: begin
                    nreq.store = 1'b1;
                    nreq.addr  = {`MMIO_FB_TAG, r[27:0]};
                end
                4'hD: begin
                    nreq.load = 1'b1;
                    nreq.addr = r[27] ? `MMIO_ADDR_CYCLES : `MMIO_ADDR_INSTRS;
                end
                4'hE: begin
                    nreq.load  = r[27];  // mostly unmapped
                    nreq.store = !r[27];
                    nreq.addr  = lcg_next();
                end
                4'hF: begin
                    nreq.store = 1'b1;
                    nreq.addr  = `MMIO_ADDR_HDMI_FIRE;
                end
            endcase
        end
        req        <= nreq;
        retire     <= s[31];
        switches   <= s[30:29];
        audio_full <= s[28];
        hdmi_ready <= s[27];
        @(negedge clk);
        check_periph(periph, exp_periph);
        check_bit(rd_valid, exp_valid);
        if (exp_valid) begin
            check_word(rd_data, exp_data);
        end
    endtask

    initial begin
        int waited;
        rng_state  = 32'hda4a_5cd6;
        named_addr = '{`MMIO_ADDR_LEDS, `MMIO_ADDR_TONE_EN, `MMIO_ADDR_TONE_PERIOD,
                       `MMIO_ADDR_AUDIO_DIN, `MMIO_ADDR_AUDIO_FULL, `MMIO_ADDR_SWITCHES,
                       `MMIO_ADDR_CYCLES, `MMIO_ADDR_INSTRS, `MMIO_ADDR_CNT_RESET,
                       `MMIO_ADDR_HDMI_X0, `MMIO_ADDR_HDMI_X1, `MMIO_ADDR_HDMI_Y0,
                       `MMIO_ADDR_HDMI_Y1, `MMIO_ADDR_HDMI_COLOR, `MMIO_ADDR_HDMI_FIRE};
        rst        = 1'b1;
        req        = '0;
        retire     = 1'b0;
        switches   = 2'b00;
        audio_full = 1'b0;
        hdmi_ready = 1'b0;

        // --------------------
        // reset
        // --------------------
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        rst                   <= 1'b0;
        exp_periph             = '0;
        exp_periph.tone_period = `MMIO_TONE_RESET;
        exp_valid              = 1'b0;
        exp_data               = '0;
        exp_cycles             = '0;
        exp_instrs             = '0;
        waited                 = 0;
        @(negedge clk);
        while (rd_valid !== 1'b0 || periph.tone_period !== `MMIO_TONE_RESET) begin
            if (waited == RESET_TIMEOUT) begin
                $display("reset: outputs not at reset values after %0d cycles", waited);
                stop_run();
            end
            waited++;
            @(posedge clk);
            step_model();
            @(negedge clk);
        end
        check_periph(periph, exp_periph);
        check_bit(rd_valid, 1'b0);

        // random traffic, then idle until every strobe has dropped
        for (int n = 0; n < N_REQ; n++) begin
            run_cycle(1'b0);
        end
        waited = 0;
        run_cycle(1'b1);
        while (rd_valid !== 1'b0 || periph.audio_wr_en !== 1'b0 || periph.fb_we !== 1'b0
               || periph.hdmi_valid !== 1'b0) begin
            if (waited == DRAIN_TIMEOUT) begin
                $display("drain: strobes still active after %0d idle cycles", waited);
                stop_run();
            end
            waited++;
            run_cycle(1'b1);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;  // 100 ns period
        end
    end

endmodule
